/* sources.f */
+incdir+source
source/io_pkg.sv
source/io_bus_decode.sv
source/display_registers.sv
source/uart_transmitter.sv
source/io_subsystem.sv
testbench/io_subsystem_properties.sv
testbench/io_subsystem_tb.sv

/* Makefile */
SIM = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP = io_subsystem_tb
FILE_LIST = sources.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/io_subsystem_tb.sv */
`default_nettype none

`include "io_params.svh"

module io_subsystem_tb;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int CLKS_PER_BIT = `IO_UART_CLKS_PER_BIT;
	localparam int NUM_BYTES = 4;
	localparam logic [2:0] NUM_FIELDS = 3'd6;
	// Register tests, then one frame per byte plus the busy test
	localparam int TEST_CYCLES = 200 + (NUM_BYTES + 1) * 13 * CLKS_PER_BIT;
	localparam int WATCHDOG_TIME = 2 * TEST_CYCLES * CLK_PERIOD;

	logic clk = 1'b0;
	logic reset;
	logic io_write_en;
	logic io_read_en;
	logic [31:0] io_address;
	logic [31:0] io_write_data;
	logic [31:0] io_read_data;
	logic [`IO_RED_LED_WIDTH-1:0] red_led;
	logic [`IO_GREEN_LED_WIDTH-1:0] green_led;
	logic [`IO_HEX_WIDTH-1:0] hex0;
	logic [`IO_HEX_WIDTH-1:0] hex1;
	logic [`IO_HEX_WIDTH-1:0] hex2;
	logic [`IO_HEX_WIDTH-1:0] hex3;
	logic uart_tx;

	// Shadow model of the indicator registers, red, green, hex0 to hex3
	logic [31:0] field_addr [6];
	logic [31:0] field_mask [6];
	logic [31:0] shadow [6];

	io_subsystem dut(.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Drive point, a little after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic check_value(string test_name, logic [31:0] expected, logic [31:0] actual);
		assert (actual == expected)
		else
		begin
			$display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
			$display("Test failures found");
			$fatal(1, "Value mismatch in %s", test_name);
		end
	endtask

	task automatic write_word(logic [31:0] addr, logic [31:0] data);
		io_write_en = 1'b1;
		io_address = addr;
		io_write_data = data;
		next_cycle();
		io_write_en = 1'b0;
	endtask

	// Strobe taken at the first edge, data registered at the second
	task automatic check_read(string test_name, logic [31:0] addr, logic [31:0] expected);
		io_read_en = 1'b1;
		io_address = addr;
		next_cycle();
		io_read_en = 1'b0;
		next_cycle();
		check_value(test_name, expected, io_read_data);
	endtask

	function automatic logic [31:0] pin_value(logic [2:0] field);
		case (field)
			3'd0: return 32'(red_led);
			3'd1: return 32'(green_led);
			3'd2: return 32'(hex0);
			3'd3: return 32'(hex1);
			3'd4: return 32'(hex2);
			default: return 32'(hex3);
		endcase
	endfunction

	// Every field, written or not, against the shadow
	task automatic check_pins(string test_name);
		logic [2:0] f;
		for (f = 3'd0; f < NUM_FIELDS; f++)
			check_value(test_name, shadow[f], pin_value(f));
	endtask

	// Sample mid bit, counted from the falling start edge
	task automatic check_frame(string test_name, logic [7:0] data);
		logic [9:0] frame;
		int b;
		frame = {1'b1, data, 1'b0};
		@(negedge uart_tx);
		repeat (CLKS_PER_BIT / 2) @(posedge clk);
		#DRIVE_DELAY;
		for (b = 0; b < 10; b++)
		begin
			check_value(test_name, {31'b0, frame[0]}, {31'b0, uart_tx});
			frame = frame >> 1;
			if (b < 9)
			begin
				repeat (CLKS_PER_BIT) @(posedge clk);
				#DRIVE_DELAY;
			end
		end
	endtask

	// Poll status until the transmitter is free
	task automatic wait_idle();
		io_read_en = 1'b1;
		io_address = `IO_ADDR_UART_STATUS;
		next_cycle();
		next_cycle();
		while (io_read_data[0])
			next_cycle();
		io_read_en = 1'b0;
		next_cycle();
	endtask

	// Starts just after the write is sampled at edge N
	task automatic check_busy_window(logic [7:0] dropped_byte);
		check_read("busy_status", `IO_ADDR_UART_STATUS, 32'd1);
		// Second byte mid frame, to be dropped
		write_word(`IO_ADDR_UART_TX, {24'd0, dropped_byte});
		check_read("busy_status", `IO_ADDR_UART_STATUS, 32'd1);
		// Now at N+5, move to N+10P-1
		repeat (10 * CLKS_PER_BIT - 6) next_cycle();
		// Two reads back to back, busy sampled at N+1+10P then N+2+10P
		io_read_en = 1'b1;
		io_address = `IO_ADDR_UART_STATUS;
		next_cycle();
		next_cycle();
		io_read_en = 1'b0;
		check_value("busy_status", 32'd1, io_read_data);
		next_cycle();
		check_value("busy_status", 32'd0, io_read_data);
	endtask

	initial
	begin
		#(WATCHDOG_TIME);
		$display("Timeout: the tests did not finish within the cycle budget");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		logic [31:0] data;
		logic [7:0] tx_byte;
		logic [2:0] f;
		int round;

		void'($urandom(2));
		reset = 1'b0;
		io_write_en = 1'b0;
		io_read_en = 1'b0;
		io_address = '0;
		io_write_data = '0;
		field_addr = '{`IO_ADDR_RED_LED, `IO_ADDR_GREEN_LED, `IO_ADDR_HEX0,
			`IO_ADDR_HEX1, `IO_ADDR_HEX2, `IO_ADDR_HEX3};
		for (f = 3'd0; f < NUM_FIELDS; f++)
		begin
			field_mask[f] = (32'd1 << (f == 3'd0 ? `IO_RED_LED_WIDTH :
				f == 3'd1 ? `IO_GREEN_LED_WIDTH : `IO_HEX_WIDTH)) - 32'd1;
			// LEDs dark, digits blank
			shadow[f] = f < 3'd2 ? 32'd0 : field_mask[f];
		end

		#DRIVE_DELAY;
		reset = 1'b1;
		repeat (5) next_cycle();
		reset = 1'b0;
		check_pins("reset_state");
		check_value("reset_state", 32'd1, {31'b0, uart_tx});
		check_value("reset_state", 32'd0, io_read_data);

		for (round = 0; round < 3; round++)
			for (f = 3'd0; f < NUM_FIELDS; f++)
			begin
				data = $urandom;
				write_word(field_addr[f], data);
				shadow[f] = data & field_mask[f];
				next_cycle();
				check_pins("indicator_write");
			end
		// Unmapped and misaligned writes
		write_word(32'h0000_0040, $urandom);
		write_word(32'h0000_0002, $urandom);
		next_cycle();
		check_pins("indicator_write");

		for (f = 3'd0; f < NUM_FIELDS; f++)
		begin
			data = $urandom;
			write_word(field_addr[f], data);
			shadow[f] = data & field_mask[f];
			check_read("readback", field_addr[f], shadow[f]);
		end
		check_read("readback", `IO_ADDR_UART_TX, 32'd0);
		check_read("readback", 32'h0000_0020, 32'd0);
		check_read("readback", 32'hffff_fffc, 32'd0);

		for (round = 0; round < NUM_BYTES; round++)
		begin
			tx_byte = 8'($urandom);
			// Upper bits of the word are ignored
			write_word(`IO_ADDR_UART_TX, {24'($urandom), tx_byte});
			check_frame("serial_frame", tx_byte);
			wait_idle();
		end

		tx_byte = 8'($urandom);
		write_word(`IO_ADDR_UART_TX, {24'd0, tx_byte});
		fork
			check_frame("busy_status", tx_byte);
			check_busy_window(~tx_byte);
		join
		// Dropped byte must not show up as a late frame
		repeat (2 * CLKS_PER_BIT)
		begin
			next_cycle();
			check_value("busy_status", 32'd1, {31'b0, uart_tx});
		end
		check_read("busy_status", `IO_ADDR_UART_STATUS, 32'd0);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/io_subsystem_properties.sv */
`default_nettype none

`include "io_params.svh"

module io_subsystem_properties
(
	input wire logic clk,
	input wire logic reset,
	input wire logic io_write_en,
	input wire logic [31:0] io_address,
	input wire logic [31:0] io_write_data,
	input wire logic [31:0] io_read_data,
	input wire logic [`IO_RED_LED_WIDTH-1:0] red_led,
	input wire logic [`IO_GREEN_LED_WIDTH-1:0] green_led,
	input wire logic [`IO_HEX_WIDTH-1:0] hex0,
	input wire logic [`IO_HEX_WIDTH-1:0] hex1,
	input wire logic [`IO_HEX_WIDTH-1:0] hex2,
	input wire logic [`IO_HEX_WIDTH-1:0] hex3,
	input wire logic uart_tx,
	input wire logic uart_busy
);

	localparam logic [`IO_HEX_WIDTH-1:0] HEX_BLANK = {`IO_HEX_WIDTH{1'b1}};

	// Reset values through reset and on the first edge after it
	reset_state: assert property (@(posedge clk) reset || $past(reset) |->
		red_led == '0 && green_led == '0 && hex0 == HEX_BLANK && hex1 == HEX_BLANK
		&& hex2 == HEX_BLANK && hex3 == HEX_BLANK && uart_tx && io_read_data == '0)
		else $error("Outputs not at their reset values around reset");

	// Written field shows on the pins two edges after the strobe is sampled
	red_write: assert property (@(posedge clk) disable iff (reset)
		$past(io_write_en && io_address == `IO_ADDR_RED_LED, 2)
		|-> red_led == $past(io_write_data[`IO_RED_LED_WIDTH-1:0], 2))
		else $error("Red LEDs missed a write");
	green_write: assert property (@(posedge clk) disable iff (reset)
		$past(io_write_en && io_address == `IO_ADDR_GREEN_LED, 2)
		|-> green_led == $past(io_write_data[`IO_GREEN_LED_WIDTH-1:0], 2))
		else $error("Green LEDs missed a write");
	hex0_write: assert property (@(posedge clk) disable iff (reset)
		$past(io_write_en && io_address == `IO_ADDR_HEX0, 2)
		|-> hex0 == $past(io_write_data[`IO_HEX_WIDTH-1:0], 2))
		else $error("Digit 0 missed a write");
	hex1_write: assert property (@(posedge clk) disable iff (reset)
		$past(io_write_en && io_address == `IO_ADDR_HEX1, 2)
		|-> hex1 == $past(io_write_data[`IO_HEX_WIDTH-1:0], 2))
		else $error("Digit 1 missed a write");
	hex2_write: assert property (@(posedge clk) disable iff (reset)
		$past(io_write_en && io_address == `IO_ADDR_HEX2, 2)
		|-> hex2 == $past(io_write_data[`IO_HEX_WIDTH-1:0], 2))
		else $error("Digit 2 missed a write");
	hex3_write: assert property (@(posedge clk) disable iff (reset)
		$past(io_write_en && io_address == `IO_ADDR_HEX3, 2)
		|-> hex3 == $past(io_write_data[`IO_HEX_WIDTH-1:0], 2))
		else $error("Digit 3 missed a write");

	// Idle transmitter keeps the line high
	idle_line_high: assert property (@(posedge clk) disable iff (reset) !uart_busy |-> uart_tx)
		else $error("Serial line low while the transmitter is idle");
	// Start bit comes out with busy
	start_with_busy: assert property (@(posedge clk) disable iff (reset)
		$rose(uart_busy) |-> !uart_tx)
		else $error("Busy rose without a start bit");

endmodule

bind io_subsystem io_subsystem_properties properties(
	.clk(clk),
	.reset(reset),
	.io_write_en(io_write_en),
	.io_address(io_address),
	.io_write_data(io_write_data),
	.io_read_data(io_read_data),
	.red_led(red_led),
	.green_led(green_led),
	.hex0(hex0),
	.hex1(hex1),
	.hex2(hex2),
	.hex3(hex3),
	.uart_tx(uart_tx),
	.uart_busy(uart_busy));

`default_nettype wire

/* source/io_subsystem.sv */
`default_nettype none

`include "io_params.svh"

module io_subsystem
	import io_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// I/O bus from the core
	input wire logic io_write_en,
	input wire logic io_read_en,
	input wire logic [31:0] io_address,
	input wire logic [31:0] io_write_data,
	output logic [31:0] io_read_data,

	// Board indicators
	output logic [`IO_RED_LED_WIDTH-1:0] red_led,
	output logic [`IO_GREEN_LED_WIDTH-1:0] green_led,
	output logic [`IO_HEX_WIDTH-1:0] hex0,
	output logic [`IO_HEX_WIDTH-1:0] hex1,
	output logic [`IO_HEX_WIDTH-1:0] hex2,
	output logic [`IO_HEX_WIDTH-1:0] hex3,

	// Serial transmit line
	output logic uart_tx
);

	io_request_t request;
	io_indicators_t indicators;
	logic uart_busy;

	io_bus_decode io_bus_decode(
		.clk(clk),
		.reset(reset),
		.io_write_en(io_write_en),
		.io_read_en(io_read_en),
		.io_address(io_address),
		.io_write_data(io_write_data),
		.request(request));

	display_registers display_registers(
		.clk(clk),
		.reset(reset),
		.request(request),
		.uart_busy(uart_busy),
		.indicators(indicators),
		.io_read_data(io_read_data));

	uart_transmitter uart_transmitter(
		.clk(clk),
		.reset(reset),
		.request(request),
		.uart_tx(uart_tx),
		.uart_busy(uart_busy));

	// Indicator state out to the pins
	assign red_led = indicators.red_led;
	assign green_led = indicators.green_led;
	assign hex0 = indicators.hex0;
	assign hex1 = indicators.hex1;
	assign hex2 = indicators.hex2;
	assign hex3 = indicators.hex3;

endmodule

`default_nettype wire

/* source/uart_transmitter.sv */
`default_nettype none

`include "io_params.svh"

module uart_transmitter
	import io_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Registered access from the decoder
	input io_request_t request,

	// Serial line, idles high
	output logic uart_tx,
	output logic uart_busy
);

	localparam int CLKS_PER_BIT = `IO_UART_CLKS_PER_BIT;
	localparam int COUNT_WIDTH = $clog2(CLKS_PER_BIT);
	localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0]
	{
		STATE_IDLE,
		STATE_START,
		STATE_DATA,
		STATE_STOP
	} tx_state_t;

	tx_state_t state;
	logic [COUNT_WIDTH-1:0] clk_count;
	logic [2:0] bit_index;
	logic [7:0] shift;
	logic accept;
	logic bit_done;

	// New byte only taken while idle, otherwise dropped
	assign accept = request.write && request.device == DEV_UART_DATA
		&& state == STATE_IDLE;
	// Last cycle of the current bit period
	assign bit_done = clk_count == LAST_COUNT;
	assign uart_busy = state != STATE_IDLE;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= STATE_IDLE;
			clk_count <= '0;
			bit_index <= '0;
			uart_tx <= 1'b1;
		end
		else if (accept)
		begin
			// Start bit goes out right away
			state <= STATE_START;
			clk_count <= '0;
			uart_tx <= 1'b0;
		end
		else if (state != STATE_IDLE)
		begin
			clk_count <= bit_done ? '0 : clk_count + 1'b1;
			if (bit_done)
			begin
				case (state)
					STATE_START:
					begin
						state <= STATE_DATA;
						bit_index <= '0;
						uart_tx <= shift[0];
					end
					STATE_DATA:
					begin
						if (bit_index == 3'd7)
						begin
							// Stop bit
							state <= STATE_STOP;
							uart_tx <= 1'b1;
						end
						else
						begin
							bit_index <= bit_index + 1'b1;
							uart_tx <= shift[0];
						end
					end
					// Stop bit done, frame complete
					default: state <= STATE_IDLE;
				endcase
			end
		end
	end

	// Data byte, LSB first
	always_ff @(posedge clk)
	begin
		if (accept)
			shift <= request.data[7:0];
		else if (bit_done && (state == STATE_START || state == STATE_DATA))
			shift <= {1'b0, shift[7:1]};
	end

endmodule

`default_nettype wire

/* source/display_registers.sv */
`default_nettype none

`include "io_params.svh"

module display_registers
	import io_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Registered access from the decoder
	input io_request_t request,
	// Transmitter activity, reported in the status word
	input wire logic uart_busy,

	output io_indicators_t indicators,
	output logic [31:0] io_read_data
);

	// Blank digit, all segments off
	localparam logic [`IO_HEX_WIDTH-1:0] HEX_OFF = {`IO_HEX_WIDTH{1'b1}};

	// Indicator registers
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			indicators.red_led <= '0;
			indicators.green_led <= '0;
			indicators.hex0 <= HEX_OFF;
			indicators.hex1 <= HEX_OFF;
			indicators.hex2 <= HEX_OFF;
			indicators.hex3 <= HEX_OFF;
		end
		else if (request.write)
		begin
			// Low bits of the data word land in the selected field
			case (request.device)
				DEV_RED_LED:
					indicators.red_led <= request.data[`IO_RED_LED_WIDTH-1:0];
				DEV_GREEN_LED:
					indicators.green_led <= request.data[`IO_GREEN_LED_WIDTH-1:0];
				DEV_HEX0:
					indicators.hex0 <= request.data[`IO_HEX_WIDTH-1:0];
				DEV_HEX1:
					indicators.hex1 <= request.data[`IO_HEX_WIDTH-1:0];
				DEV_HEX2:
					indicators.hex2 <= request.data[`IO_HEX_WIDTH-1:0];
				DEV_HEX3:
					indicators.hex3 <= request.data[`IO_HEX_WIDTH-1:0];
				// UART and unmapped devices are not ours
				default:
				begin
				end
			endcase
		end
	end

	// Readback word, held until the next read
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			io_read_data <= '0;
		else if (request.read)
		begin
			case (request.device)
				DEV_RED_LED: io_read_data <= 32'(indicators.red_led);
				DEV_GREEN_LED: io_read_data <= 32'(indicators.green_led);
				DEV_HEX0: io_read_data <= 32'(indicators.hex0);
				DEV_HEX1: io_read_data <= 32'(indicators.hex1);
				DEV_HEX2: io_read_data <= 32'(indicators.hex2);
				DEV_HEX3: io_read_data <= 32'(indicators.hex3);
				// Busy level in bit 0
				DEV_UART_STATUS: io_read_data <= {31'b0, uart_busy};
				// Transmit data is write only, unmapped reads as zero
				default: io_read_data <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/io_bus_decode.sv */
`default_nettype none

`include "io_params.svh"

module io_bus_decode
	import io_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Plain strobes from the core, no handshake
	input wire logic io_write_en,
	input wire logic io_read_en,
	input wire logic [31:0] io_address,
	input wire logic [31:0] io_write_data,

	// Registered access for the register block and transmitter
	output io_request_t request
);

	io_device_t device_next;
	logic write_q;
	logic read_q;
	io_device_t device_q;
	logic [31:0] data_q;

	// Address map lookup
	// Only exact word addresses hit, anything else selects nothing
	always_comb
	begin
		case (io_address)
			`IO_ADDR_RED_LED: device_next = DEV_RED_LED;
			`IO_ADDR_GREEN_LED: device_next = DEV_GREEN_LED;
			`IO_ADDR_HEX0: device_next = DEV_HEX0;
			`IO_ADDR_HEX1: device_next = DEV_HEX1;
			`IO_ADDR_HEX2: device_next = DEV_HEX2;
			`IO_ADDR_HEX3: device_next = DEV_HEX3;
			`IO_ADDR_UART_TX: device_next = DEV_UART_DATA;
			`IO_ADDR_UART_STATUS: device_next = DEV_UART_STATUS;
			default: device_next = DEV_NONE;
		endcase
	end

	// Strobes and select, one cycle behind the bus
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			write_q <= 1'b0;
			read_q <= 1'b0;
			device_q <= DEV_NONE;
		end
		else
		begin
			write_q <= io_write_en;
			read_q <= io_read_en;
			device_q <= device_next;
		end
	end

	// Write data rides along with the strobes
	always_ff @(posedge clk)
		data_q <= io_write_data;

	assign request = '{
		write: write_q,
		read: read_q,
		device: device_q,
		data: data_q
	};

endmodule

`default_nettype wire

/* source/io_pkg.sv */
`default_nettype none

`include "io_params.svh"

package io_pkg;

	// Device picked out by a decoded bus address
	typedef enum logic [3:0]
	{
		DEV_NONE,
		DEV_RED_LED,
		DEV_GREEN_LED,
		DEV_HEX0,
		DEV_HEX1,
		DEV_HEX2,
		DEV_HEX3,
		DEV_UART_DATA,
		DEV_UART_STATUS
	} io_device_t;

	// One registered bus access
	// Flags are only valid for a single cycle
	typedef struct packed
	{
		logic write;
		logic read;
		io_device_t device;
		logic [31:0] data;
	} io_request_t;

	// Current state of the board indicators
	typedef struct packed
	{
		logic [`IO_RED_LED_WIDTH-1:0] red_led;
		logic [`IO_GREEN_LED_WIDTH-1:0] green_led;
		// Segment patterns, zero lights a segment
		logic [`IO_HEX_WIDTH-1:0] hex0;
		logic [`IO_HEX_WIDTH-1:0] hex1;
		logic [`IO_HEX_WIDTH-1:0] hex2;
		logic [`IO_HEX_WIDTH-1:0] hex3;
	} io_indicators_t;

endpackage

`default_nettype wire

/* source/io_params.svh */
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Byte addresses of the I/O registers
`define IO_ADDR_RED_LED 32'h00
`define IO_ADDR_GREEN_LED 32'h04
`define IO_ADDR_HEX0 32'h08
`define IO_ADDR_HEX1 32'h0c
`define IO_ADDR_HEX2 32'h10
`define IO_ADDR_HEX3 32'h14
`define IO_ADDR_UART_TX 32'h18
`define IO_ADDR_UART_STATUS 32'h1c

// Indicator field widths
`define IO_RED_LED_WIDTH 18
`define IO_GREEN_LED_WIDTH 9
// Raw segment pattern, active low
`define IO_HEX_WIDTH 7

// Clocks per serial bit, at least 2
`define IO_UART_CLKS_PER_BIT 8

`endif
